//--- bootRom.hex
// Boot ROM image: 16 bytes per line, addresses 0x000 to 0x1FF in order
// Byte is addr[7:0] in the lower half and its inverse in the upper half
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F
30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
40 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F
50 51 52 53 54 55 56 57 58 59 5A 5B 5C 5D 5E 5F
60 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F
70 71 72 73 74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F
90 91 92 93 94 95 96 97 98 99 9A 9B 9C 9D 9E 9F
A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF
B0 B1 B2 B3 B4 B5 B6 B7 B8 B9 BA BB BC BD BE BF
C0 C1 C2 C3 C4 C5 C6 C7 C8 C9 CA CB CC CD CE CF
D0 D1 D2 D3 D4 D5 D6 D7 D8 D9 DA DB DC DD DE DF
E0 E1 E2 E3 E4 E5 E6 E7 E8 E9 EA EB EC ED EE EF
F0 F1 F2 F3 F4 F5 F6 F7 F8 F9 FA FB FC FD FE FF
FF FE FD FC FB FA F9 F8 F7 F6 F5 F4 F3 F2 F1 F0
EF EE ED EC EB EA E9 E8 E7 E6 E5 E4 E3 E2 E1 E0
DF DE DD DC DB DA D9 D8 D7 D6 D5 D4 D3 D2 D1 D0
CF CE CD CC CB CA C9 C8 C7 C6 C5 C4 C3 C2 C1 C0
BF BE BD BC BB BA B9 B8 B7 B6 B5 B4 B3 B2 B1 B0
AF AE AD AC AB AA A9 A8 A7 A6 A5 A4 A3 A2 A1 A0
9F 9E 9D 9C 9B 9A 99 98 97 96 95 94 93 92 91 90
8F 8E 8D 8C 8B 8A 89 88 87 86 85 84 83 82 81 80
7F 7E 7D 7C 7B 7A 79 78 77 76 75 74 73 72 71 70
6F 6E 6D 6C 6B 6A 69 68 67 66 65 64 63 62 61 60
5F 5E 5D 5C 5B 5A 59 58 57 56 55 54 53 52 51 50
4F 4E 4D 4C 4B 4A 49 48 47 46 45 44 43 42 41 40
3F 3E 3D 3C 3B 3A 39 38 37 36 35 34 33 32 31 30
2F 2E 2D 2C 2B 2A 29 28 27 26 25 24 23 22 21 20
1F 1E 1D 1C 1B 1A 19 18 17 16 15 14 13 12 11 10
0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00

//--- tb.f
hostPkg.sv
busDecoder.sv
bootRom.sv
workRam.sv
uartTx.sv
hostBoard.sv
tb_hostBoard.sv

//--- Bender.yml
package:
  name: hostBoard

sources:
  - hostPkg.sv
  - busDecoder.sv
  - bootRom.sv
  - workRam.sv
  - uartTx.sv
  - hostBoard.sv
  - target: test
    files:
      - tb_hostBoard.sv

//--- tb_hostBoard.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host board testbench
// CPU bus cycle tasks, compare tasks
// Directed tests for reset, memories, UART, IRQ
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_hostBoard;

   logic        pll_clk;
   logic        rstN;
   logic        intKey;
   logic        nmiKey;
   logic [15:0] addr;
   logic [7:0]  dataIn;
   logic        nM1;
   logic        nMREQ;
   logic        nIORQ;
   logic        nRD;
   logic        nWR;
   logic        nRFSH;
   logic        cpuClk;
   logic        cpuRstN;
   logic        nINT;
   logic        nNMI;
   logic [7:0]  dataOut;
   logic        dataOutEn;
   logic        uartTxd;

   int          errorCount = 0;
   int          timeoutCount = 0;
   // Rising pll_clk edges since time zero
   int unsigned cycleCount = 0;

   // Reference copy of the ROM image and a model of the RAM
   logic [7:0] romImage [0:hostPkg::MEM_DEPTH-1];
   logic [7:0] ramModel [0:hostPkg::MEM_DEPTH-1];

   hostBoard hostBoard_i (
      .pll_clk   (pll_clk),
      .rstN      (rstN),
      .intKey    (intKey),
      .nmiKey    (nmiKey),
      .addr      (addr),
      .dataIn    (dataIn),
      .nM1       (nM1),
      .nMREQ     (nMREQ),
      .nIORQ     (nIORQ),
      .nRD       (nRD),
      .nWR       (nWR),
      .nRFSH     (nRFSH),
      .cpuClk    (cpuClk),
      .cpuRstN   (cpuRstN),
      .nINT      (nINT),
      .nNMI      (nNMI),
      .dataOut   (dataOut),
      .dataOutEn (dataOutEn),
      .uartTxd   (uartTxd)
   );

   // 8 ns pll_clk
   initial
   begin
      pll_clk = 1'b0;
      forever
      begin
         #4 pll_clk = !pll_clk;
      end
   end

   always @(posedge pll_clk)
   begin
      cycleCount <= cycleCount + 1;
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Compare tasks
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic checkByte(input string sig, input hostPkg::busCycle_e cyc,
                            input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s in %s cycle, got 8'h%02h, expected 8'h%02h",
                  $time, sig, cyc.name(), got, exp);
         errorCount++;
      end
   endtask

   task automatic checkBit(input string sig, input hostPkg::busCycle_e cyc,
                           input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s in %s cycle, got %b, expected %b",
                  $time, sig, cyc.name(), got, exp);
         errorCount++;
      end
   endtask

   // Cycle counts such as the cpuClk half period
   task automatic checkCount(input string sig, input int got, input int exp);
      if (got != exp)
      begin
         $display("mismatch at %0t: %s, got %0d, expected %0d", $time, sig, got, exp);
         errorCount++;
      end
   endtask

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // CPU bus cycles
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Strobe pattern of each cycle driven 1 ns after the edge
   task automatic setBus(input hostPkg::busCycle_e cyc, input logic [15:0] a,
                         input logic [7:0] d);
      @(posedge pll_clk);
      #1;
      addr   = a;
      dataIn = d;
      nM1    = 1'b1;
      nMREQ  = 1'b1;
      nIORQ  = 1'b1;
      nRD    = 1'b1;
      nWR    = 1'b1;
      nRFSH  = 1'b1;
      case (cyc)
         hostPkg::MEM_READ:
         begin
            nMREQ = 1'b0;
            nRD   = 1'b0;
         end
         hostPkg::MEM_WRITE:
         begin
            nMREQ = 1'b0;
            nWR   = 1'b0;
         end
         hostPkg::IO_READ:
         begin
            nIORQ = 1'b0;
            nRD   = 1'b0;
         end
         hostPkg::IO_WRITE:
         begin
            nIORQ = 1'b0;
            nWR   = 1'b0;
         end
         hostPkg::INT_ACK:
         begin
            nM1   = 1'b0;
            nIORQ = 1'b0;
         end
         // Read strobe left active so refresh must override it
         hostPkg::REFRESH:
         begin
            nMREQ = 1'b0;
            nRD   = 1'b0;
            nRFSH = 1'b0;
         end
         default:
         begin
         end
      endcase
   endtask

   // Memory byte is registered and valid after one edge
   task automatic memRead(input logic [15:0] a, output logic [7:0] d, output logic en);
      setBus(hostPkg::MEM_READ, a, 8'h00);
      @(posedge pll_clk);
      @(negedge pll_clk);
      d  = dataOut;
      en = dataOutEn;
      setBus(hostPkg::IDLE, a, 8'h00);
   endtask

   task automatic memWrite(input logic [15:0] a, input logic [7:0] d);
      setBus(hostPkg::MEM_WRITE, a, d);
      setBus(hostPkg::IDLE, a, d);
   endtask

   // Status is combinational and sampled in the same cycle
   task automatic ioRead(output logic [7:0] d);
      setBus(hostPkg::IO_READ, 16'($urandom), 8'h00);
      @(negedge pll_clk);
      d = dataOut;
      checkBit("dataOutEn", hostPkg::IO_READ, dataOutEn, 1'b1);
      setBus(hostPkg::IDLE, 16'h0000, 8'h00);
   endtask

   // Strobe held over two edges gives one transmit request
   task automatic ioWrite(input logic [7:0] d);
      setBus(hostPkg::IO_WRITE, 16'($urandom), d);
      @(posedge pll_clk);
      setBus(hostPkg::IDLE, 16'h0000, d);
   endtask

   task automatic intAck(output logic [7:0] d, output logic en);
      setBus(hostPkg::INT_ACK, 16'h0000, 8'h00);
      @(negedge pll_clk);
      d  = dataOut;
      en = dataOutEn;
      setBus(hostPkg::IDLE, 16'h0000, 8'h00);
   endtask

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wait helpers
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Runs to the negedge where cycleCount reaches target
   task automatic waitForCycle(input int unsigned target);
      int guard;
      guard = 0;
      while (cycleCount < target && guard < 20 * hostPkg::UART_BIT_CYCLES)
      begin
         @(negedge pll_clk);
         guard++;
      end
      if (cycleCount < target)
      begin
         $display("timeout at %0t: cycle %0d never reached", $time, target);
         timeoutCount++;
      end
   endtask

   // Polls the status port until the busy flag clears
   task automatic waitUartIdle();
      logic [7:0] status;
      int         guard;
      status = 8'h01;
      guard  = 0;
      while (status[0] && guard < 10 * hostPkg::UART_BIT_CYCLES)
      begin
         ioRead(status);
         guard++;
      end
      if (status[0])
      begin
         $display("timeout at %0t: UART busy flag never cleared", $time);
         timeoutCount++;
      end
      else
      begin
         checkByte("dataOut", hostPkg::IO_READ, status, 8'h00);
      end
   endtask

   // Samples uartTxd mid-bit and rebuilds the byte LSB first
   task automatic captureFrame(input logic injectWrite, input logic [7:0] otherByte,
                               output logic [7:0] rxByte);
      int unsigned startCycle;
      int unsigned bitLen;
      int          guard;
      logic [7:0]  status;
      bitLen = hostPkg::UART_BIT_CYCLES;
      rxByte = 8'hxx;
      guard  = 0;
      @(negedge pll_clk);
      while (uartTxd !== 1'b0 && guard < 4 * hostPkg::CPU_DIV_HALF + 8)
      begin
         @(negedge pll_clk);
         guard++;
      end
      if (uartTxd !== 1'b0)
      begin
         $display("timeout at %0t: no start bit on uartTxd", $time);
         timeoutCount++;
      end
      else
      begin
         startCycle = cycleCount;
         // Busy must show while the start bit is out
         ioRead(status);
         checkByte("dataOut", hostPkg::IO_READ, status, 8'h01);
         waitForCycle(startCycle + bitLen / 2);
         checkBit("uartTxd start bit", hostPkg::IDLE, uartTxd, 1'b0);
         for (int k = 1; k <= 8; k++)
         begin
            // Second write lands in the middle of the data bits
            if (injectWrite && k == 2)
            begin
               ioWrite(otherByte);
            end
            waitForCycle(startCycle + k * bitLen + bitLen / 2);
            rxByte[k-1] = uartTxd;
         end
         waitForCycle(startCycle + 9 * bitLen + bitLen / 2);
         checkBit("uartTxd stop bit", hostPkg::IDLE, uartTxd, 1'b1);
      end
   endtask

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Directed tests
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic resetState();
      logic        prevClk;
      int unsigned lastToggle;
      int          toggles;
      int          guard;
      repeat (7) @(posedge pll_clk);
      @(negedge pll_clk);
      checkBit("cpuClk", hostPkg::IDLE, cpuClk, 1'b0);
      checkBit("uartTxd", hostPkg::IDLE, uartTxd, 1'b1);
      checkBit("cpuRstN", hostPkg::IDLE, cpuRstN, 1'b0);
      checkBit("dataOutEn", hostPkg::IDLE, dataOutEn, 1'b0);
      // Eighth reset edge and then release
      @(posedge pll_clk);
      #1;
      rstN = 1'b1;
      @(posedge pll_clk);
      @(negedge pll_clk);
      checkBit("cpuRstN", hostPkg::IDLE, cpuRstN, 1'b1);
      checkBit("uartTxd", hostPkg::IDLE, uartTxd, 1'b1);
      // Half period measured between observed toggles
      prevClk    = cpuClk;
      lastToggle = 0;
      toggles    = 0;
      guard      = 0;
      while (toggles < 5 && guard < 20 * hostPkg::CPU_DIV_HALF)
      begin
         @(negedge pll_clk);
         guard++;
         if (cpuClk !== prevClk)
         begin
            if (toggles > 0)
            begin
               checkCount("cpuClk half period", cycleCount - lastToggle,
                          hostPkg::CPU_DIV_HALF);
            end
            prevClk    = cpuClk;
            lastToggle = cycleCount;
            toggles++;
         end
      end
      if (toggles < 5)
      begin
         $display("timeout at %0t: cpuClk stopped toggling", $time);
         timeoutCount++;
      end
      // All four key combinations
      for (int i = 0; i < 4; i++)
      begin
         @(posedge pll_clk);
         #1;
         intKey = i[0];
         nmiKey = i[1];
         @(negedge pll_clk);
         checkBit("nINT", hostPkg::IDLE, nINT, !i[0]);
         checkBit("nNMI", hostPkg::IDLE, nNMI, !i[1]);
      end
   endtask

   // Random upper bits exercise the 1 KB mirror
   task automatic romReads();
      logic [15:0] a;
      logic [7:0]  d;
      logic        en;
      for (int i = 0; i < 24; i++)
      begin
         a = 16'($urandom);
         a[hostPkg::RAM_SELECT_BIT] = 1'b0;
         memRead(a, d, en);
         checkByte("dataOut", hostPkg::MEM_READ, d, romImage[a[8:0]]);
         checkBit("dataOutEn", hostPkg::MEM_READ, en, 1'b1);
      end
   endtask

   task automatic ramWriteRead();
      logic [15:0] addrList [0:15];
      logic [15:0] a;
      logic [7:0]  d;
      logic        en;
      for (int i = 0; i < 16; i++)
      begin
         a = 16'($urandom);
         a[hostPkg::RAM_SELECT_BIT] = 1'b1;
         d = 8'($urandom);
         memWrite(a, d);
         ramModel[a[8:0]] = d;
         addrList[i] = a;
      end
      // Read back through a different mirror
      for (int i = 0; i < 16; i++)
      begin
         a = addrList[i];
         a[15:10] = 6'($urandom);
         memRead(a, d, en);
         checkByte("dataOut", hostPkg::MEM_READ, d, ramModel[a[8:0]]);
      end
      // ROM write with the same low bits touches neither memory
      a = addrList[0];
      a[hostPkg::RAM_SELECT_BIT] = 1'b0;
      memWrite(a, ~romImage[a[8:0]]);
      memRead(a, d, en);
      checkByte("dataOut", hostPkg::MEM_READ, d, romImage[a[8:0]]);
      a[hostPkg::RAM_SELECT_BIT] = 1'b1;
      memRead(a, d, en);
      checkByte("dataOut", hostPkg::MEM_READ, d, ramModel[a[8:0]]);
   endtask

   task automatic uartFrame();
      logic [7:0] txByte;
      logic [7:0] rxByte;
      txByte = 8'($urandom);
      ioWrite(txByte);
      captureFrame(1'b0, 8'h00, rxByte);
      checkByte("uartTxd frame", hostPkg::IO_WRITE, rxByte, txByte);
      waitUartIdle();
   endtask

   task automatic droppedWrite();
      logic [7:0] txByte;
      logic [7:0] rxByte;
      txByte = 8'($urandom);
      ioWrite(txByte);
      captureFrame(1'b1, ~txByte, rxByte);
      checkByte("uartTxd frame", hostPkg::IO_WRITE, rxByte, txByte);
      // No second frame may follow the stop bit
      for (int i = 0; i < 3 * hostPkg::UART_BIT_CYCLES; i++)
      begin
         @(negedge pll_clk);
         checkBit("uartTxd after dropped write", hostPkg::IDLE, uartTxd, 1'b1);
      end
      waitUartIdle();
   endtask

   task automatic intAckAndRefresh();
      logic [7:0] d;
      logic       en;
      intAck(d, en);
      checkByte("dataOut", hostPkg::INT_ACK, d, hostPkg::INT_VECTOR);
      checkBit("dataOutEn", hostPkg::INT_ACK, en, 1'b1);
      setBus(hostPkg::REFRESH, 16'($urandom), 8'h00);
      @(negedge pll_clk);
      checkBit("dataOutEn", hostPkg::REFRESH, dataOutEn, 1'b0);
      setBus(hostPkg::IDLE, 16'h0000, 8'h00);
      @(negedge pll_clk);
      checkBit("dataOutEn", hostPkg::IDLE, dataOutEn, 1'b0);
   endtask

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Main sequence
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial
   begin
      void'($urandom(32'h852e));
      rstN   = 1'b0;
      intKey = 1'b0;
      nmiKey = 1'b0;
      addr   = 16'h0000;
      dataIn = 8'h00;
      nM1    = 1'b1;
      nMREQ  = 1'b1;
      nIORQ  = 1'b1;
      nRD    = 1'b1;
      nWR    = 1'b1;
      nRFSH  = 1'b1;
      $readmemh("bootRom.hex", romImage);

      resetState();
      romReads();
      ramWriteRead();
      uartFrame();
      droppedWrite();
      intAckAndRefresh();

      $display("errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
      if (errorCount == 0 && timeoutCount == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- hostBoard.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host board top level
// CPU clock divider, reset register, key inverters
// Bus decoder, boot ROM, work RAM, UART
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module hostBoard
(
   input  logic        pll_clk,
   input  logic        rstN,
   // Keys, active high
   input  logic        intKey,
   input  logic        nmiKey,
   // CPU bus pins
   input  logic [15:0] addr,
   input  logic [7:0]  dataIn,
   input  logic        nM1,
   input  logic        nMREQ,
   input  logic        nIORQ,
   input  logic        nRD,
   input  logic        nWR,
   input  logic        nRFSH,
   // To the CPU
   output logic        cpuClk,
   output logic        cpuRstN,
   output logic        nINT,
   output logic        nNMI,
   output logic [7:0]  dataOut,
   output logic        dataOutEn,
   // Serial line
   output logic        uartTxd
);

   logic [7:0] romData;
   logic [7:0] ramData;
   logic       ramWe;
   logic       uartWr;
   logic       uartBusy;
   logic [hostPkg::CPU_DIV_BITS-1:0] divCnt;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // CPU clock and reset
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // cpuClk toggles every CPU_DIV_HALF pll_clk cycles
   always_ff @(posedge pll_clk)
   begin
      if (!rstN)
      begin
         divCnt <= '0;
         cpuClk <= 1'b0;
      end
      else if (divCnt == hostPkg::CPU_DIV_LAST)
      begin
         divCnt <= '0;
         cpuClk <= !cpuClk;
      end
      else
      begin
         divCnt <= divCnt + 1'b1;
      end
   end

   // CPU reset one pll_clk behind the board reset
   always_ff @(posedge pll_clk)
   begin
      cpuRstN <= rstN;
   end

   // Keys straight to the active-low interrupt pins
   assign nINT = !intKey;
   assign nNMI = !nmiKey;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bus decode
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   busDecoder busDecoder_i (
      .pll_clk   (pll_clk),
      .rstN      (rstN),
      .addr      (addr),
      .dataIn    (dataIn),
      .nIORQ     (nIORQ),
      .nRD       (nRD),
      .nWR       (nWR),
      .nRFSH     (nRFSH),
      .romData   (romData),
      .ramData   (ramData),
      .uartBusy  (uartBusy),
      .ramWe     (ramWe),
      .uartWr    (uartWr),
      .dataOut   (dataOut),
      .dataOutEn (dataOutEn)
   );

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Memories
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Both see only the low 9 address bits
   bootRom bootRom_i (
      .pll_clk (pll_clk),
      .addr    (addr[hostPkg::ROM_ADDR_BITS-1:0]),
      .romData (romData)
   );

   workRam workRam_i (
      .pll_clk (pll_clk),
      .addr    (addr[hostPkg::ROM_ADDR_BITS-1:0]),
      .we      (ramWe),
      .wrData  (dataIn),
      .ramData (ramData)
   );

   // UART, byte taken from the CPU data pins
   uartTx uartTx_i (
      .pll_clk (pll_clk),
      .rstN    (rstN),
      .wr      (uartWr),
      .txData  (dataIn),
      .busy    (uartBusy),
      .txd     (uartTxd)
   );

   // Decoder ignores nMREQ, so memory and IO strobes must not overlap
   assert property (@(posedge pll_clk) disable iff (!rstN)
      !(!nMREQ && !nIORQ))
      else $error("nMREQ and nIORQ low together");

   // M1 with IORQ is an interrupt acknowledge, never a read or write
   assert property (@(posedge pll_clk) disable iff (!rstN)
      (!nM1 && !nIORQ) |-> (nRD && nWR))
      else $error("interrupt acknowledge with nRD or nWR active");

endmodule

//--- uartTx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 serial transmitter
// Bit timer, shift register, busy flag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module uartTx
(
   input  logic       pll_clk,
   input  logic       rstN,
   input  logic       wr,
   input  logic [7:0] txData,
   output logic       busy,
   output logic       txd
);

   hostPkg::uartState_e state;
   // pll_clk count within the current bit
   logic [hostPkg::UART_CNT_BITS-1:0] bitTimer;
   // Data bit index, LSB first
   logic [2:0] bitIdx;
   // Remaining data bits, bit 0 goes out next
   logic [7:0] shiftReg;
   logic       bitEnd;

   assign bitEnd = (bitTimer == hostPkg::UART_BIT_LAST);

   // Busy from the registered state, same edge as the start bit
   assign busy = (state != hostPkg::TX_IDLE);

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Transmit FSM
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge pll_clk)
   begin
      if (!rstN)
      begin
         state    <= hostPkg::TX_IDLE;
         bitTimer <= '0;
         bitIdx   <= '0;
         txd      <= 1'b1;
      end
      else
      begin
         // Timer runs only while a frame is out
         if (state == hostPkg::TX_IDLE || bitEnd)
         begin
            bitTimer <= '0;
         end
         else
         begin
            bitTimer <= bitTimer + 1'b1;
         end

         case (state)
            hostPkg::TX_IDLE:
            begin
               // New byte accepted only here, writes while busy are lost
               if (wr)
               begin
                  state <= hostPkg::TX_START;
                  txd   <= 1'b0;
               end
            end
            hostPkg::TX_START:
            begin
               if (bitEnd)
               begin
                  state  <= hostPkg::TX_DATA;
                  bitIdx <= '0;
                  txd    <= shiftReg[0];
               end
            end
            hostPkg::TX_DATA:
            begin
               if (bitEnd)
               begin
                  if (bitIdx == 3'd7)
                  begin
                     state <= hostPkg::TX_STOP;
                     txd   <= 1'b1;
                  end
                  else
                  begin
                     bitIdx <= bitIdx + 1'b1;
                     txd    <= shiftReg[0];
                  end
               end
            end
            hostPkg::TX_STOP:
            begin
               // Line already high, back to idle after one bit time
               if (bitEnd)
               begin
                  state <= hostPkg::TX_IDLE;
               end
            end
            default:
            begin
               state <= hostPkg::TX_IDLE;
               txd   <= 1'b1;
            end
         endcase
      end
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Shift register, payload only
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge pll_clk)
   begin
      if (state == hostPkg::TX_IDLE && wr)
      begin
         shiftReg <= txData;
      end
      else if (bitEnd && (state == hostPkg::TX_START || state == hostPkg::TX_DATA))
      begin
         shiftReg <= shiftReg >> 1;
      end
   end

   // Idle line must be at mark level
   assert property (@(posedge pll_clk) disable iff (!rstN)
      (state == hostPkg::TX_IDLE) |-> txd)
      else $error("txd low while transmitter idle");

endmodule

//--- workRam.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 512-byte work RAM
// Single port, read before write
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module workRam
(
   input  logic                              pll_clk,
   input  logic [hostPkg::ROM_ADDR_BITS-1:0] addr,
   input  logic                              we,
   input  logic [7:0]                        wrData,
   output logic [7:0]                        ramData
);

   // Storage array
   logic [7:0] mem [0:hostPkg::MEM_DEPTH-1];

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Write and registered read
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge pll_clk)
   begin
      // Store on every edge while the write decode holds
      if (we)
      begin
         mem[addr] <= wrData;
      end
      // Old contents returned during a write
      ramData <= mem[addr];
   end

endmodule

//--- bootRom.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 512-byte boot ROM
// Synchronous read, image from bootRom.hex
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module bootRom
(
   input  logic                              pll_clk,
   input  logic [hostPkg::ROM_ADDR_BITS-1:0] addr,
   output logic [7:0]                        romData
);

   // ROM array
   logic [7:0] mem [0:hostPkg::MEM_DEPTH-1];

   // Image loaded once at elaboration
   initial
   begin
      $readmemh("bootRom.hex", mem);
   end

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Registered read port
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Byte valid one pll_clk after the address
   always_ff @(posedge pll_clk)
   begin
      romData <= mem[addr];
   end

endmodule

//--- busDecoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Z80 bus decoder
// Cycle classification, RAM write enable,
// UART write pulse and read-data mux
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module busDecoder
(
   input  logic        pll_clk,
   input  logic        rstN,
   input  logic [15:0] addr,
   input  logic [7:0]  dataIn,
   input  logic        nIORQ,
   input  logic        nRD,
   input  logic        nWR,
   input  logic        nRFSH,
   input  logic [7:0]  romData,
   input  logic [7:0]  ramData,
   input  logic        uartBusy,
   output logic        ramWe,
   output logic        uartWr,
   output logic [7:0]  dataOut,
   output logic        dataOutEn
);

   hostPkg::busCycle_e cycle;
   // IO write decode seen on the previous pll_clk
   logic ioWrPrev;
   logic ioWrNow;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Cycle classification
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      case ({nIORQ, nRD, nWR})
         3'b101:  cycle = hostPkg::MEM_READ;
         3'b110:  cycle = hostPkg::MEM_WRITE;
         3'b001:  cycle = hostPkg::IO_READ;
         3'b010:  cycle = hostPkg::IO_WRITE;
         // IORQ alone is the interrupt acknowledge
         3'b011:  cycle = hostPkg::INT_ACK;
         default: cycle = hostPkg::IDLE;
      endcase
      // Refresh overrides everything, the bus stays released
      if (!nRFSH)
      begin
         cycle = hostPkg::REFRESH;
      end
   end

   // RAM writes only in the upper half of each 1 KB mirror
   assign ramWe = (cycle == hostPkg::MEM_WRITE) && addr[hostPkg::RAM_SELECT_BIT];

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // UART write pulse
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign ioWrNow = (cycle == hostPkg::IO_WRITE);

   always_ff @(posedge pll_clk)
   begin
      if (!rstN)
      begin
         ioWrPrev <= 1'b0;
      end
      else
      begin
         ioWrPrev <= ioWrNow;
      end
   end

   // Rising edge of the level strobe, first pll_clk of the IO write only
   assign uartWr = ioWrNow && !ioWrPrev;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Read-data mux
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      case (cycle)
         hostPkg::MEM_READ:
         begin
            // Upper address bits ignored, map repeats every 1 KB
            dataOut = addr[hostPkg::RAM_SELECT_BIT] ? ramData : romData;
         end
         // Status port, busy flag in bit 0 at any port address
         hostPkg::IO_READ: dataOut = {7'b0000000, uartBusy};
         hostPkg::INT_ACK: dataOut = hostPkg::INT_VECTOR;
         // Not driving, echo the CPU byte
         default:          dataOut = dataIn;
      endcase
   end

   assign dataOutEn = (cycle == hostPkg::MEM_READ) ||
                      (cycle == hostPkg::IO_READ)  ||
                      (cycle == hostPkg::INT_ACK);

   // A long IO write strobe must still give a single transmit request
   assert property (@(posedge pll_clk) disable iff (!rstN)
      uartWr |=> !uartWr)
      else $error("uartWr high on two consecutive cycles");

endmodule

//--- hostPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host board shared definitions
// Memory map, clock and UART timing
// Interrupt vector, bus-cycle and UART state enums
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package hostPkg;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Memory map
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Each region is 512 bytes
   localparam int ROM_ADDR_BITS = 9;
   localparam int MEM_DEPTH = 1 << ROM_ADDR_BITS;
   // Bit 9 set selects RAM, clear selects ROM
   localparam int RAM_SELECT_BIT = 9;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Timing
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // pll_clk cycles per half period of cpuClk
   localparam int CPU_DIV_HALF = 2;
   localparam int CPU_DIV_BITS = (CPU_DIV_HALF > 1) ? $clog2(CPU_DIV_HALF) : 1;
   localparam logic [CPU_DIV_BITS-1:0] CPU_DIV_LAST = CPU_DIV_BITS'(CPU_DIV_HALF - 1);

   // pll_clk cycles per serial bit
   localparam int UART_BIT_CYCLES = 16;
   localparam int UART_CNT_BITS = (UART_BIT_CYCLES > 1) ? $clog2(UART_BIT_CYCLES) : 1;
   localparam logic [UART_CNT_BITS-1:0] UART_BIT_LAST = UART_CNT_BITS'(UART_BIT_CYCLES - 1);

   // Byte put on the bus during interrupt acknowledge (IM2 vector)
   localparam logic [7:0] INT_VECTOR = 8'h80;

   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Enums
   //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Decoded bus cycle, from nIORQ/nRD/nWR and nRFSH
   typedef enum logic [2:0] {
      IDLE,
      MEM_READ,
      MEM_WRITE,
      IO_READ,
      IO_WRITE,
      INT_ACK,
      REFRESH
   } busCycle_e;

   // Serial transmitter states
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } uartState_e;

endpackage
